//--- list.f
hw/mem_stage_pkg.sv
hw/addr_translate.sv
hw/exc_prioritize.sv
hw/mem_access_ctrl.sv
hw/store_align.sv
hw/mem_stage_top.sv
verification/mem_stage_tb.sv

//--- Makefile
TOP := mem_stage_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int CLK_NS     = 20;
    localparam int N_XLATE    = 200;
    localparam int N_EXC      = 300;
    localparam int N_STORE    = 72;
    localparam int N_LINK     = 30;
    localparam int TIMEOUT_NS = (2 + N_XLATE + N_EXC + N_STORE + N_LINK + 100) * CLK_NS;
    localparam word_t LINK_A  = 32'h8000_0100;

    logic       clk;
    logic       arst_n;
    mem_op_t    op;
    word_t      vaddr, rt_data, pc;
    exc_info_t  upstream;
    tlb_entry_t tlb;
    logic       interrupt, overflow, trap, eret_flush;
    mem_req_t   req;
    exc_info_t  exc;
    word_t      sc_result;

    // reference model state and outputs
    logic       ref_link;
    word_t      ref_link_addr;
    logic       ref_mapped, ref_sc_ok, ref_intent, ref_en, ref_miss, ref_own;
    logic       ref_misalign;
    logic [1:0] ref_off;
    word_t      ref_paddr, ref_wdata;
    wstrb_t     ref_wstrb;
    exc_info_t  ref_exc;
    exc_code_t  ref_fault_code;
    logic       ref_fault;

    integer seed = 73587;
    int     errors = 0;
    int     tests_run = 0;
    int     start;

    mem_stage_top dut (
        .clk(clk), .arst_n(arst_n), .op(op), .vaddr(vaddr), .rt_data(rt_data), .pc(pc),
        .upstream(upstream), .tlb(tlb), .interrupt(interrupt), .overflow(overflow),
        .trap(trap), .eret_flush(eret_flush), .req(req), .exc(exc), .sc_result(sc_result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always_comb begin
        ref_mapped = op.access && (!vaddr[31] || vaddr[31:30] == 2'b11);
        if (ref_mapped)
            ref_paddr = {tlb.pfn, vaddr[PAGE_BITS-1:0]};
        else
            ref_paddr = vaddr & ((32'h1 << UNMAPPED_BITS) - 32'h1);
        ref_sc_ok  = op.sc && ref_link && ref_link_addr == vaddr;
        ref_intent = op.wr && !upstream.exc && !eret_flush && (!op.sc || ref_sc_ok);
        ref_own    = !upstream.exc;
        ref_miss   = !tlb.found || !tlb.valid;
        ref_fault  = 1'b0;
        ref_fault_code = EXC_INT;
        if (ref_mapped && ref_own) begin
            ref_fault = ref_intent ? (ref_miss || !tlb.dirty) : ref_miss;
            ref_fault_code = !ref_intent ? EXC_TLBL : (ref_miss ? EXC_TLBS : EXC_MOD);
        end
        ref_misalign = op.kind == KIND_NORMAL &&
                       ((op.size == SZ_WORD && vaddr[1:0] != 2'b00) ||
                        (op.size == SZ_HALF && vaddr[0]));
        ref_exc.refill   = (ref_own && ref_mapped && !tlb.found && op.access) || upstream.refill;
        ref_exc.exc      = 1'b1;
        ref_exc.badvaddr = 32'h0;
        if (interrupt)
            ref_exc.code = EXC_INT;
        else if (ref_own && overflow)
            ref_exc.code = EXC_OV;
        else if (ref_own && trap)
            ref_exc.code = EXC_TR;
        else if (ref_own && ref_misalign && (op.wr || (op.rd && op.rfwr))) begin
            ref_exc.code     = op.wr ? EXC_ADES : EXC_ADEL;    // store check first
            ref_exc.badvaddr = vaddr;
        end else if (ref_fault) begin
            ref_exc.code     = ref_fault_code;
            ref_exc.badvaddr = vaddr;
        end else begin
            ref_exc.exc      = upstream.exc;
            ref_exc.code     = upstream.code;
            ref_exc.badvaddr = pc;
        end
        ref_en = op.access && !ref_exc.exc && !eret_flush && (!op.sc || ref_sc_ok);
    end

    // per-lane view of the store rules
    always_comb begin
        ref_off   = ref_paddr[1:0];
        ref_wstrb = '0;
        ref_wdata = '0;
        for (int i = 0; i < 4; i++) begin
            if (op.kind == KIND_LEFT) begin
                ref_wstrb[i] = (i <= int'(ref_off));
                if (i <= int'(ref_off))
                    ref_wdata[8*i +: 8] = rt_data[8*(i + 3 - int'(ref_off)) +: 8];
            end else if (op.kind == KIND_RIGHT) begin
                ref_wstrb[i] = (i >= int'(ref_off));
                if (i >= int'(ref_off))
                    ref_wdata[8*i +: 8] = rt_data[8*(i - int'(ref_off)) +: 8];
            end else begin
                ref_wdata[8*i +: 8] = rt_data[8*i +: 8];
                if (op.size == SZ_BYTE)
                    ref_wstrb[i] = (i == int'(ref_off));
                else if (op.size == SZ_HALF)
                    ref_wstrb[i] = ((i >> 1) == int'(ref_off[1]));
                else
                    ref_wstrb[i] = 1'b1;
            end
        end
        if (!ref_intent)
            ref_wstrb = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ref_link      <= 1'b0;
            ref_link_addr <= '0;
        end else if (ref_exc.exc || eret_flush) begin
            ref_link <= 1'b0;
        end else if (op.ll) begin
            ref_link      <= 1'b1;
            ref_link_addr <= vaddr;
        end
    end

    task automatic report_mismatch(input string name, input word_t expv, input word_t got);
        errors++;
        $display("Fail %s: expected %h, got %h", name, expv, got);
    endtask

    a_addr: assert property (@(posedge clk) disable iff (!arst_n) req.addr == ref_paddr)
        else report_mismatch("req.addr", $sampled(ref_paddr), $sampled(req.addr));
    a_en: assert property (@(posedge clk) disable iff (!arst_n) req.en == ref_en)
        else report_mismatch("req.en", 32'($sampled(ref_en)), 32'($sampled(req.en)));
    a_wen: assert property (@(posedge clk) disable iff (!arst_n) req.wen == ref_intent)
        else report_mismatch("req.wen", 32'($sampled(ref_intent)), 32'($sampled(req.wen)));
    a_wstrb: assert property (@(posedge clk) disable iff (!arst_n) req.wstrb == ref_wstrb)
        else report_mismatch("req.wstrb", 32'($sampled(ref_wstrb)), 32'($sampled(req.wstrb)));
    a_wdata: assert property (@(posedge clk) disable iff (!arst_n) req.wdata == ref_wdata)
        else report_mismatch("req.wdata", $sampled(ref_wdata), $sampled(req.wdata));
    a_exc: assert property (@(posedge clk) disable iff (!arst_n) exc.exc == ref_exc.exc)
        else report_mismatch("exc.exc", 32'($sampled(ref_exc.exc)), 32'($sampled(exc.exc)));
    a_code: assert property (@(posedge clk) disable iff (!arst_n) exc.code == ref_exc.code)
        else report_mismatch("exc.code", 32'($sampled(ref_exc.code)), 32'($sampled(exc.code)));
    a_badv: assert property (@(posedge clk) disable iff (!arst_n)
                             exc.badvaddr == ref_exc.badvaddr)
        else report_mismatch("exc.badvaddr", $sampled(ref_exc.badvaddr),
                             $sampled(exc.badvaddr));
    a_refill: assert property (@(posedge clk) disable iff (!arst_n)
                               exc.refill == ref_exc.refill)
        else report_mismatch("exc.refill", 32'($sampled(ref_exc.refill)),
                             32'($sampled(exc.refill)));
    a_sc: assert property (@(posedge clk) disable iff (!arst_n) sc_result == 32'(ref_en))
        else report_mismatch("sc_result", 32'($sampled(ref_en)), $sampled(sc_result));

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    function automatic mem_op_t make_op(input logic store, input logic [1:0] sz,
                                        input logic [1:0] kd);
        mem_op_t o;
        o        = '0;
        o.access = 1'b1;
        o.rd     = !store;
        o.wr     = store;
        o.rfwr   = !store;
        o.size   = mem_size_e'(sz == 2'd3 ? 2'd2 : sz);
        o.kind   = mem_kind_e'(kd == 2'd3 ? 2'd0 : kd);
        return o;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_inputs();
        op         = '0;
        vaddr      = '0;
        rt_data    = '0;
        pc         = '0;
        upstream   = '0;
        tlb        = '0;
        interrupt  = 1'b0;
        overflow   = 1'b0;
        trap       = 1'b0;
        eret_flush = 1'b0;
    endtask

    task automatic drive_random(input logic with_faults);
        word_t r1, r3, r4;
        next_cycle();
        clear_inputs();
        r1      = $random(seed);
        r3      = $random(seed);
        op      = make_op(r1[0], r1[2:1], r1[4:3]);
        op.ll   = !r1[0] && r1[7:5] == 3'd0;
        op.sc   = r1[0] && r1[10:8] == 3'd0;
        vaddr   = $random(seed);
        rt_data = $random(seed);
        pc      = $random(seed);
        tlb     = r3[22:0];
        if (with_faults) begin
            r4              = $random(seed);
            interrupt       = r4[2:0] == 3'd0;
            overflow        = r4[5:3] == 3'd0;
            trap            = r4[8:6] == 3'd0;
            eret_flush      = r4[12:9] == 4'd0;
            upstream.exc    = r4[14:13] == 2'd0;
            upstream.code   = r4[19:15];
            upstream.refill = upstream.exc & r4[20];    // upstream refill implies exc
            if (r4[23])
                vaddr[1:0] = 2'b00;
        end
    endtask

    task automatic mem_access(input logic store, input word_t addr, input logic linked);
        next_cycle();
        clear_inputs();
        op      = make_op(store, 2'd2, 2'd0);
        op.ll   = linked & !store;
        op.sc   = linked & store;
        vaddr   = addr;
        rt_data = $random(seed);
    endtask

    task automatic apply_reset();
        next_cycle();
        clear_inputs();
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
    endtask

    task automatic end_test(input string name, input int first_err);
        @(posedge clk);
        #1;
        tests_run++;
        $display("test %s done, %0d failed checks", name, errors - first_err);
    endtask

    initial begin
        clear_inputs();
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        start = errors;
        repeat (N_XLATE) drive_random(1'b0);
        end_test("translation", start);

        start = errors;
        repeat (N_EXC) drive_random(1'b1);
        end_test("exception priority", start);

        start = errors;
        for (int s = 0; s < 3; s++)
            for (int k = 0; k < 3; k++)
                for (int o = 0; o < 4; o++)
                    for (int q = 0; q < 2; q++) begin
                        next_cycle();
                        clear_inputs();
                        op         = make_op(1'b1, 2'(s), 2'(k));
                        vaddr      = 32'h8000_0040 | 32'(o);    // kseg0, offset o
                        rt_data    = $random(seed);
                        eret_flush = (q == 1);
                    end
        end_test("store align", start);

        start = errors;
        apply_reset();
        mem_access(1'b1, LINK_A, 1'b1);    // sc with no link
        mem_access(1'b0, LINK_A, 1'b1);
        mem_access(1'b1, LINK_A, 1'b1);
        mem_access(1'b0, LINK_A, 1'b1);
        next_cycle();
        clear_inputs();
        next_cycle();
        mem_access(1'b1, LINK_A, 1'b1);
        mem_access(1'b0, LINK_A, 1'b1);
        mem_access(1'b1, LINK_A + 32'h4, 1'b1);
        end_test("ll/sc", start);

        start = errors;
        mem_access(1'b0, LINK_A, 1'b1);
        next_cycle();
        clear_inputs();
        interrupt = 1'b1;
        mem_access(1'b1, LINK_A, 1'b1);
        mem_access(1'b0, LINK_A, 1'b1);
        next_cycle();
        clear_inputs();
        eret_flush = 1'b1;
        mem_access(1'b1, LINK_A, 1'b1);
        mem_access(1'b0, LINK_A, 1'b1);
        mem_access(1'b0, LINK_A + 32'h1, 1'b0);    // misaligned lw, adel
        mem_access(1'b1, LINK_A, 1'b1);
        end_test("link clear", start);

        $display("tests run %0d, failed checks %0d", tests_run, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- hw/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  mem_op_t    op,
    input  word_t      vaddr,
    input  word_t      rt_data,
    input  word_t      pc,
    input  exc_info_t  upstream,
    input  tlb_entry_t tlb,
    input  logic       interrupt,
    input  logic       overflow,
    input  logic       trap,
    input  logic       eret_flush,
    output mem_req_t   req,
    output exc_info_t  exc,
    output word_t      sc_result
);

    logic       store_intent;
    logic       req_en;
    word_t      paddr;
    tlb_fault_e tlb_fault;
    logic       refill;
    wstrb_t     wstrb;
    word_t      wdata;

    addr_translate u_addr_translate (
        .op              (op),
        .vaddr           (vaddr),
        .tlb             (tlb),
        .upstream_exc    (upstream.exc),
        .upstream_refill (upstream.refill),
        .store_intent    (store_intent),
        .paddr           (paddr),
        .tlb_fault       (tlb_fault),
        .refill          (refill)
    );

    exc_prioritize u_exc_prioritize (
        .op        (op),
        .vaddr     (vaddr),
        .pc        (pc),
        .upstream  (upstream),
        .tlb_fault (tlb_fault),
        .refill    (refill),
        .interrupt (interrupt),
        .overflow  (overflow),
        .trap      (trap),
        .exc       (exc)
    );

    // final exc loops back to block the request and drop the link
    mem_access_ctrl u_mem_access_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .op           (op),
        .vaddr        (vaddr),
        .upstream_exc (upstream.exc),
        .eret_flush   (eret_flush),
        .final_exc    (exc.exc),
        .store_intent (store_intent),
        .req_en       (req_en),
        .sc_result    (sc_result)
    );

    store_align u_store_align (
        .op           (op),
        .paddr        (paddr),
        .rt_data      (rt_data),
        .store_intent (store_intent),
        .wstrb        (wstrb),
        .wdata        (wdata)
    );

    assign req.en    = req_en;
    assign req.wen   = store_intent;
    assign req.addr  = paddr;
    assign req.wstrb = wstrb;
    assign req.wdata = wdata;

endmodule

//--- hw/store_align.sv
`timescale 1ns/1ps

module store_align import mem_stage_pkg::*; (
    input  mem_op_t op,
    input  word_t   paddr,
    input  word_t   rt_data,
    input  logic    store_intent,
    output wstrb_t  wstrb,
    output word_t   wdata
);

    logic [1:0] off;
    logic [4:0] shamt_left;
    logic [4:0] shamt_right;

    assign off = paddr[1:0];

    // byte shift counts as bit counts
    assign shamt_left  = {2'd3 - off, 3'b000};
    assign shamt_right = {off, 3'b000};

    always_comb begin
        wstrb = 4'b0000;
        if (store_intent) begin
            case (op.kind)
                KIND_LEFT: begin
                    // swl fills lanes 0..off
                    case (off)
                        2'd0:    wstrb = 4'b0001;
                        2'd1:    wstrb = 4'b0011;
                        2'd2:    wstrb = 4'b0111;
                        default: wstrb = 4'b1111;
                    endcase
                end
                KIND_RIGHT: begin
                    // swr fills lanes off..3
                    case (off)
                        2'd0:    wstrb = 4'b1111;
                        2'd1:    wstrb = 4'b1110;
                        2'd2:    wstrb = 4'b1100;
                        default: wstrb = 4'b1000;
                    endcase
                end
                default: begin
                    case (op.size)
                        SZ_BYTE: wstrb = 4'b0001 << off;
                        SZ_HALF: wstrb = paddr[1] ? 4'b1100 : 4'b0011;
                        default: wstrb = 4'b1111;
                    endcase
                end
            endcase
        end
    end

    always_comb begin
        case (op.kind)
            KIND_LEFT:  wdata = rt_data >> shamt_left;    // msb end to lane off
            KIND_RIGHT: wdata = rt_data << shamt_right;
            default:    wdata = rt_data;
        endcase
    end

    always_comb begin
        assert (store_intent || wstrb == 4'b0000)
            else $error("write strobe %b without store intent", wstrb);
    end

endmodule

//--- hw/mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl import mem_stage_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  mem_op_t op,
    input  word_t   vaddr,
    input  logic    upstream_exc,
    input  logic    eret_flush,
    input  logic    final_exc,
    output logic    store_intent,
    output logic    req_en,
    output word_t   sc_result
);

    logic  link_valid;
    word_t link_addr;
    logic  sc_ok;
    logic  sc_pass;    // not an sc, or an sc that may go
    logic  link_kill;

    assign sc_ok   = op.sc & link_valid & (link_addr == vaddr);
    assign sc_pass = ~op.sc | sc_ok;

    // independent of final_exc, feeds the tlb fault check
    assign store_intent = op.wr & ~upstream_exc & ~eret_flush & sc_pass;

    assign req_en    = op.access & ~final_exc & ~eret_flush & sc_pass;
    assign sc_result = {31'b0, req_en};

    assign link_kill = final_exc | eret_flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            link_valid <= 1'b0;
        else if (link_kill)
            link_valid <= 1'b0;
        else if (op.ll)
            link_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (op.ll && !link_kill)
            link_addr <= vaddr;    // only meaningful while link_valid
    end

    a_no_req_on_exc: assert property (
        @(posedge clk) disable iff (!arst_n) !(req_en && final_exc)
    ) else $error("memory request issued alongside exception");

endmodule

//--- hw/exc_prioritize.sv
`timescale 1ns/1ps

module exc_prioritize import mem_stage_pkg::*; (
    input  mem_op_t    op,
    input  word_t      vaddr,
    input  word_t      pc,
    input  exc_info_t  upstream,
    input  tlb_fault_e tlb_fault,
    input  logic       refill,
    input  logic       interrupt,
    input  logic       overflow,
    input  logic       trap,
    output exc_info_t  exc
);

    logic      misalign;
    logic      ades;
    logic      adel;
    logic      own_ok;    // this stage may raise its own causes
    exc_code_t tlb_code;

    assign own_ok = ~upstream.exc;

    // left/right variants are never misaligned
    assign misalign = (op.kind == KIND_NORMAL) &
                      (((op.size == SZ_WORD) & (vaddr[1:0] != 2'b00)) |
                       ((op.size == SZ_HALF) & vaddr[0]));

    assign ades = own_ok & op.wr & misalign;
    assign adel = own_ok & op.rd & op.rfwr & misalign;

    always_comb begin
        case (tlb_fault)
            TF_LOAD:  tlb_code = EXC_TLBL;
            TF_STORE: tlb_code = EXC_TLBS;
            TF_MOD:   tlb_code = EXC_MOD;
            default:  tlb_code = EXC_INT;
        endcase
    end

    always_comb begin
        exc.exc      = 1'b1;
        exc.code     = EXC_INT;
        exc.refill   = refill;
        exc.badvaddr = '0;
        if (interrupt) begin
            exc.code = EXC_INT;    // beats upstream too
        end else if (own_ok && overflow) begin
            exc.code = EXC_OV;
        end else if (own_ok && trap) begin
            exc.code = EXC_TR;
        end else if (ades) begin
            exc.code     = EXC_ADES;
            exc.badvaddr = vaddr;
        end else if (adel) begin
            exc.code     = EXC_ADEL;
            exc.badvaddr = vaddr;
        end else if (own_ok && tlb_fault != TF_NONE) begin
            exc.code     = tlb_code;
            exc.badvaddr = vaddr;
        end else begin
            // earlier address faults point at the pc
            exc.exc      = upstream.exc;
            exc.code     = upstream.code;
            exc.badvaddr = pc;
        end
    end

    // a refill must always come with a raised exception
    always_comb begin
        assert (exc.exc || !refill)
            else $error("refill flagged without exception, code %h", exc.code);
    end

endmodule

//--- hw/addr_translate.sv
`timescale 1ns/1ps

module addr_translate import mem_stage_pkg::*; (
    input  mem_op_t    op,
    input  word_t      vaddr,
    input  tlb_entry_t tlb,
    input  logic       upstream_exc,
    input  logic       upstream_refill,
    input  logic       store_intent,
    output word_t      paddr,
    output tlb_fault_e tlb_fault,
    output logic       refill
);

    logic mapped;
    logic tlb_miss;    // no entry or entry invalid
    logic check_tlb;

    // kuseg and kseg2/3 go through the tlb
    assign mapped = op.access & (~vaddr[31] | (vaddr[31] & vaddr[30]));

    assign paddr = mapped ? {tlb.pfn, vaddr[PAGE_BITS-1:0]}
                          : {{(32-UNMAPPED_BITS){1'b0}}, vaddr[UNMAPPED_BITS-1:0]};

    assign tlb_miss  = ~tlb.found | ~tlb.valid;
    assign check_tlb = mapped & ~upstream_exc;

    always_comb begin
        tlb_fault = TF_NONE;
        if (check_tlb) begin
            if (store_intent) begin
                if (tlb_miss)
                    tlb_fault = TF_STORE;
                else if (!tlb.dirty)
                    tlb_fault = TF_MOD;    // clean page, write protected
            end else if (tlb_miss) begin
                tlb_fault = TF_LOAD;
            end
        end
    end

    // own refill only on a true miss; upstream refill rides along
    assign refill = (~upstream_exc & mapped & ~tlb.found & op.access) | upstream_refill;

    always_comb begin
        assert (mapped || tlb_fault == TF_NONE)
            else $error("tlb fault on unmapped address %h", vaddr);
    end

endmodule

//--- hw/mem_stage_pkg.sv
package mem_stage_pkg;

    typedef logic [31:0] word_t;
    typedef logic [19:0] pfn_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [3:0]  wstrb_t;

    // cp0 cause codes raised or passed by this stage
    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_OV   = 5'd12;
    localparam exc_code_t EXC_TR   = 5'd13;

    localparam int UNMAPPED_BITS = 29;  // kseg0/kseg1 window
    localparam int PAGE_BITS     = 12;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    // left/right cover lwl/swl and lwr/swr
    typedef enum logic [1:0] {
        KIND_NORMAL = 2'd0,
        KIND_LEFT   = 2'd1,
        KIND_RIGHT  = 2'd2
    } mem_kind_e;

    typedef enum logic [1:0] {
        TF_NONE  = 2'd0,
        TF_LOAD  = 2'd1,
        TF_STORE = 2'd2,
        TF_MOD   = 2'd3
    } tlb_fault_e;

    typedef struct packed {
        logic      access;  // load or store in this slot
        logic      rd;
        logic      wr;
        logic      rfwr;
        mem_size_e size;
        mem_kind_e kind;
        logic      ll;
        logic      sc;
    } mem_op_t;

    typedef struct packed {
        logic found;
        logic valid;
        logic dirty;
        pfn_t pfn;
    } tlb_entry_t;

    typedef struct packed {
        logic      exc;
        exc_code_t code;
        logic      refill;  // tlb refill vector
        word_t     badvaddr;
    } exc_info_t;

    typedef struct packed {
        logic   en;
        logic   wen;
        word_t  addr;
        wstrb_t wstrb;
        word_t  wdata;
    } mem_req_t;

endpackage
